// ==== design/ex_pkg.sv ====
`default_nettype none

package ex_pkg;

    localparam int XLEN        = 64;
    localparam int WORD_WIDTH  = 32;
    localparam int REGNO_WIDTH = 5;

    typedef logic [REGNO_WIDTH-1:0] regno_t;
    typedef logic [XLEN-1:0]        xword_t;

    // PC step between instructions, also the link offset
    localparam xword_t INSN_BYTES = xword_t'(4);

    typedef enum logic [5:0]
    {
        OP_NOP,
        // Register ALU ops
        OP_ADD,
        OP_SUB,
        OP_SLL,
        OP_SLT,
        OP_SLTU,
        OP_XOR,
        OP_SRL,
        OP_SRA,
        OP_OR,
        OP_AND,
        // Immediate ops
        OP_ADDI,
        OP_SLTI,
        OP_SLTIU,
        OP_XORI,
        OP_ORI,
        OP_ANDI,
        OP_SLLI,
        OP_SRLI,
        OP_SRAI,
        // 32-bit word ops
        OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
        OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
        OP_LUI,
        OP_AUIPC,
        OP_JAL,
        OP_JALR,
        // Branches
        OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
        OP_LOAD,
        OP_STORE
    } op_e;

endpackage

`default_nettype wire

// ==== design/operand_forward.sv ====
`default_nettype none

module operand_forward import ex_pkg::*;
(
    input  regno_t rs1,
    input  regno_t rs2,
    input  xword_t rs1_value,
    input  xword_t rs2_value,
    input  logic   uses_rs2,
    input  regno_t alu_rd,
    input  logic   alu_write_rd,
    input  logic   alu_load,
    input  xword_t alu_result,
    input  regno_t mm_rd,
    input  logic   mm_write_rd,
    input  logic   mm_load,
    input  xword_t mm_result,
    input  xword_t mm_mdata,
    input  regno_t wb_rd,
    input  logic   wb_write_rd,
    input  xword_t wb_data,
    output xword_t src1,
    output xword_t src2,
    output logic   load_use
);

    // Youngest producer wins, x0 is never forwarded
    function automatic xword_t forward_value(input regno_t src, input xword_t rf_value);
        xword_t value;
        if (src == '0)
            value = rf_value;
        else if (alu_write_rd && (src == alu_rd))
            value = alu_result;
        else if (mm_load && (src == mm_rd))
            value = mm_mdata;
        else if (mm_write_rd && (src == mm_rd))
            value = mm_result;
        else if (wb_write_rd && (src == wb_rd))
            value = wb_data;
        else
            value = rf_value;
        return value;
    endfunction

    always_comb
    begin
        src1 = forward_value(rs1, rs1_value);
        src2 = forward_value(rs2, rs2_value);
    end

    // Load one ahead has no data yet, so a reader of its rd must wait a cycle
    assign load_use = alu_load && (alu_rd != '0) &&
                      ((rs1 == alu_rd) || (uses_rs2 && (rs2 == alu_rd)));

endmodule

`default_nettype wire

// ==== design/int_alu.sv ====
`default_nettype none

module int_alu import ex_pkg::*;
(
    input  op_e    op,
    input  xword_t src1,
    input  xword_t src2,
    input  xword_t imm,
    input  xword_t pc,
    output xword_t result,
    output logic   write_rd,
    output logic   load
);

    xword_t                operand_b;
    logic [5:0]            shamt;
    logic [4:0]            word_shamt;
    logic [WORD_WIDTH-1:0] word_a;
    logic [WORD_WIDTH-1:0] word_result;

    always_comb
    begin
        case (op)
            OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI,
            OP_SLLI, OP_SRLI, OP_SRAI,
            OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW:
                operand_b = imm;
            default:
                operand_b = src2;
        endcase
    end

    assign shamt      = operand_b[5:0];
    assign word_shamt = operand_b[4:0];
    assign word_a     = src1[WORD_WIDTH-1:0];

    // Low word of the W forms, sign extended below
    always_comb
    begin
        case (op)
            OP_ADDW, OP_ADDIW:
                word_result = word_a + operand_b[WORD_WIDTH-1:0];
            OP_SUBW:
                word_result = word_a - operand_b[WORD_WIDTH-1:0];
            OP_SLLW, OP_SLLIW:
                word_result = word_a << word_shamt;
            OP_SRLW, OP_SRLIW:
                word_result = word_a >> word_shamt;
            OP_SRAW, OP_SRAIW:
                word_result = $signed(word_a) >>> word_shamt;
            default:
                word_result = '0;
        endcase
    end

    always_comb
    begin
        result   = '0;
        write_rd = 1'b1;
        case (op)
            OP_ADD, OP_ADDI:
                result = src1 + operand_b;
            OP_SUB:
                result = src1 - operand_b;
            OP_SLL, OP_SLLI:
                result = src1 << shamt;
            OP_SLT, OP_SLTI:
                result = xword_t'($signed(src1) < $signed(operand_b));
            OP_SLTU, OP_SLTIU:
                result = xword_t'(src1 < operand_b);
            OP_XOR, OP_XORI:
                result = src1 ^ operand_b;
            OP_SRL, OP_SRLI:
                result = src1 >> shamt;
            OP_SRA, OP_SRAI:
                result = $signed(src1) >>> shamt;
            OP_OR, OP_ORI:
                result = src1 | operand_b;
            OP_AND, OP_ANDI:
                result = src1 & operand_b;
            OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
            OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW:
                result = {{(XLEN-WORD_WIDTH){word_result[WORD_WIDTH-1]}}, word_result};
            OP_LUI:
                result = imm;
            OP_AUIPC:
                result = pc + imm;
            OP_JAL, OP_JALR:
                result = pc + INSN_BYTES;
            OP_LOAD, OP_STORE:
            begin
                // Effective address; rd of a load is written by the memory stage
                result   = src1 + imm;
                write_rd = 1'b0;
            end
            default:
                write_rd = 1'b0;
        endcase
    end

    assign load = (op == OP_LOAD);

endmodule

`default_nettype wire

// ==== design/branch_resolve.sv ====
`default_nettype none

module branch_resolve import ex_pkg::*;
(
    input  op_e    op,
    input  xword_t src1,
    input  xword_t src2,
    input  xword_t imm,
    input  xword_t pc,
    output logic   redirect,
    output xword_t next_pc
);

    logic   taken;
    xword_t target;

    always_comb
    begin
        case (op)
            OP_BEQ:
                taken = (src1 == src2);
            OP_BNE:
                taken = (src1 != src2);
            OP_BLT:
                taken = ($signed(src1) < $signed(src2));
            OP_BGE:
                taken = ($signed(src1) >= $signed(src2));
            OP_BLTU:
                taken = (src1 < src2);
            OP_BGEU:
                taken = (src1 >= src2);
            OP_JAL, OP_JALR:
                taken = 1'b1;
            default:
                taken = 1'b0;
        endcase
    end

    // jalr is register relative, everything else PC relative
    assign target = ((op == OP_JALR) ? src1 : pc) + imm;

    assign redirect = taken;

    always_comb
    begin
        if (!taken)
            next_pc = pc + INSN_BYTES;
        else if (op == OP_JALR)
            next_pc = {target[XLEN-1:1], 1'b0};
        else
            next_pc = target;
    end

endmodule

`default_nettype wire

// ==== design/execute_stage.sv ====
`default_nettype none

module execute_stage import ex_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   in_valid,
    output logic   ready,
    input  op_e    op,
    input  regno_t rd,
    input  regno_t rs1,
    input  regno_t rs2,
    input  xword_t rs1_value,
    input  xword_t rs2_value,
    input  xword_t imm,
    input  xword_t pc,
    input  logic   flush,
    input  regno_t alu_rd,
    input  logic   alu_write_rd,
    input  logic   alu_load,
    input  xword_t alu_result,
    input  regno_t mm_rd,
    input  logic   mm_write_rd,
    input  logic   mm_load,
    input  xword_t mm_result,
    input  xword_t mm_mdata,
    input  regno_t wb_rd,
    input  logic   wb_write_rd,
    input  xword_t wb_data,
    output logic   out_valid,
    output op_e    out_op,
    output regno_t out_rd,
    output xword_t out_result,
    output xword_t out_store_data,
    output logic   out_write_rd,
    output logic   out_load,
    output logic   out_redirect,
    output xword_t out_next_pc
);

    logic   uses_rs1;
    logic   uses_rs2;
    regno_t rs1_read;
    xword_t src1;
    xword_t src2;
    logic   load_use;
    xword_t result;
    logic   write_rd;
    logic   load;
    logic   redirect;
    xword_t next_pc;
    logic   accept;

    always_comb
    begin
        case (op)
            OP_NOP, OP_LUI, OP_AUIPC, OP_JAL:
                uses_rs1 = 1'b0;
            default:
                uses_rs1 = 1'b1;
        endcase
        case (op)
            OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
            OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
            OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_STORE:
                uses_rs2 = 1'b1;
            default:
                uses_rs2 = 1'b0;
        endcase
    end

    // An rs1 the opcode ignores is seen as x0, so it can never stall
    assign rs1_read = uses_rs1 ? rs1 : '0;

    operand_forward u_forward (
        .rs1          (rs1_read),
        .rs2          (rs2),
        .rs1_value    (rs1_value),
        .rs2_value    (rs2_value),
        .uses_rs2     (uses_rs2),
        .alu_rd       (alu_rd),
        .alu_write_rd (alu_write_rd),
        .alu_load     (alu_load),
        .alu_result   (alu_result),
        .mm_rd        (mm_rd),
        .mm_write_rd  (mm_write_rd),
        .mm_load      (mm_load),
        .mm_result    (mm_result),
        .mm_mdata     (mm_mdata),
        .wb_rd        (wb_rd),
        .wb_write_rd  (wb_write_rd),
        .wb_data      (wb_data),
        .src1         (src1),
        .src2         (src2),
        .load_use     (load_use)
    );

    int_alu u_alu (
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .pc       (pc),
        .result   (result),
        .write_rd (write_rd),
        .load     (load)
    );

    branch_resolve u_branch (
        .op       (op),
        .src1     (src1),
        .src2     (src2),
        .imm      (imm),
        .pc       (pc),
        .redirect (redirect),
        .next_pc  (next_pc)
    );

    assign ready  = !load_use;
    assign accept = in_valid && ready && !flush;

    // Anything but an accept leaves a bubble for the memory stage
    always_ff @(posedge clk)
    begin
        if (reset || !accept)
        begin
            out_valid      <= 1'b0;
            out_op         <= OP_NOP;
            out_rd         <= '0;
            out_result     <= '0;
            out_store_data <= '0;
            out_write_rd   <= 1'b0;
            out_load       <= 1'b0;
            out_redirect   <= 1'b0;
            out_next_pc    <= '0;
        end
        else
        begin
            out_valid      <= 1'b1;
            out_op         <= op;
            out_rd         <= rd;
            out_result     <= result;
            out_store_data <= src2;
            out_write_rd   <= write_rd;
            out_load       <= load;
            out_redirect   <= redirect;
            out_next_pc    <= next_pc;
        end
    end

endmodule

`default_nettype wire

// ==== verif/execute_stage_assertions.sv ====
`default_nettype none

module execute_stage_assertions
(
    input wire logic clk,
    input wire logic reset,
    input wire logic in_valid,
    input wire logic ready,
    input wire logic flush,
    input wire logic out_valid,
    input wire logic out_write_rd,
    input wire logic out_load,
    input wire logic out_redirect
);

    // A bubble carries no side effects
    bubble_is_quiet: assert property (@(posedge clk)
        !out_valid |-> !(out_write_rd || out_load || out_redirect))
        else $error("bubble with a control flag set");

    flush_drops: assert property (@(posedge clk) disable iff (reset)
        flush |=> !out_valid)
        else $error("flushed instruction reached the output");

    stall_drops: assert property (@(posedge clk) disable iff (reset)
        (in_valid && !ready) |=> !out_valid)
        else $error("stalled instruction reached the output");

endmodule

bind execute_stage execute_stage_assertions u_assertions (.*);

`default_nettype wire

// ==== verif/execute_stage_tb.sv ====
`default_nettype none

module execute_stage_tb import ex_pkg::*;
();

    localparam int ALU_TESTS      = 40;
    localparam int W_TESTS        = 18;
    localparam int BRANCH_TESTS   = 14;
    localparam int FWD_TESTS      = 6;
    localparam int PLANNED_ACCEPT = ALU_TESTS + W_TESTS + BRANCH_TESTS + FWD_TESTS + 1;
    // Reset, load-use stalls, flush and idle gaps
    localparam int STALL_CYCLES   = 8 + 2 + 1 + 10;
    localparam int TIMEOUT        = (PLANNED_ACCEPT + STALL_CYCLES) * 20 * 2;

    logic   clk;
    logic   reset;
    logic   in_valid;
    logic   ready;
    op_e    op;
    regno_t rd;
    regno_t rs1;
    regno_t rs2;
    xword_t rs1_value;
    xword_t rs2_value;
    xword_t imm;
    xword_t pc;
    logic   flush;
    regno_t alu_rd;
    logic   alu_write_rd;
    logic   alu_load;
    xword_t alu_result;
    regno_t mm_rd;
    logic   mm_write_rd;
    logic   mm_load;
    xword_t mm_result;
    xword_t mm_mdata;
    regno_t wb_rd;
    logic   wb_write_rd;
    xword_t wb_data;
    logic   out_valid;
    op_e    out_op;
    regno_t out_rd;
    xword_t out_result;
    xword_t out_store_data;
    logic   out_write_rd;
    logic   out_load;
    logic   out_redirect;
    xword_t out_next_pc;

    // Expected outputs for the instruction offered this cycle
    logic   exp_accept;
    xword_t exp_result;
    xword_t exp_store_data;
    xword_t exp_next_pc;
    logic   exp_write_rd;
    logic   exp_load;
    logic   exp_redirect;
    regno_t exp_rd;
    op_e    exp_op;

    string       test_name;
    int          word_errors;
    int          flag_errors;
    int          regno_errors;
    int          op_errors;
    logic [31:0] lfsr_state;

    execute_stage UUT (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR, taps 32 22 2 1, one step per bit
    function automatic xword_t rand_bits(input int n);
        xword_t value;
        logic   fb;
        value = '0;
        for (int i = 0; i < n; i++)
        begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = {value[XLEN-2:0], fb};
        end
        return value;
    endfunction

    function automatic logic reads_rs1(input op_e o);
        return !(o inside {OP_NOP, OP_LUI, OP_AUIPC, OP_JAL});
    endfunction

    function automatic logic reads_rs2(input op_e o);
        return o inside {OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
                         OP_OR, OP_AND, OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                         OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU, OP_STORE};
    endfunction

    // ALU stage, then memory (load data first), then writeback, then register file
    function automatic xword_t resolve_src(input regno_t src, input xword_t rf);
        if (src == '0)
            return rf;
        if (alu_write_rd && src == alu_rd)
            return alu_result;
        if (mm_load && src == mm_rd)
            return mm_mdata;
        if (mm_write_rd && src == mm_rd)
            return mm_result;
        if (wb_write_rd && src == wb_rd)
            return wb_data;
        return rf;
    endfunction

    function automatic void ref_execute(input op_e o, input xword_t s1, input xword_t s2,
        input xword_t im, input xword_t p, output xword_t res, output logic wr,
        output logic ld, output logic redir, output xword_t npc);
        xword_t      b;
        logic [31:0] w;
        logic [4:0]  ws;
        b = (o inside {OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI, OP_ANDI, OP_SLLI,
                       OP_SRLI, OP_SRAI, OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW}) ? im : s2;
        ws = b[4:0];
        w = '0;
        res = '0;
        wr = 1'b1;
        redir = 1'b0;
        case (o)
            OP_ADD, OP_ADDI:   res = s1 + b;
            OP_SUB:            res = s1 - b;
            OP_SLL, OP_SLLI:   res = s1 << b[5:0];
            OP_SLT, OP_SLTI:   res = {63'b0, $signed(s1) < $signed(b)};
            OP_SLTU, OP_SLTIU: res = {63'b0, s1 < b};
            OP_XOR, OP_XORI:   res = s1 ^ b;
            OP_SRL, OP_SRLI:   res = s1 >> b[5:0];
            OP_SRA, OP_SRAI:   res = xword_t'($signed(s1) >>> b[5:0]);
            OP_OR, OP_ORI:     res = s1 | b;
            OP_AND, OP_ANDI:   res = s1 & b;
            OP_ADDW, OP_ADDIW: w = s1[31:0] + b[31:0];
            OP_SUBW:           w = s1[31:0] - b[31:0];
            OP_SLLW, OP_SLLIW: w = s1[31:0] << ws;
            OP_SRLW, OP_SRLIW: w = s1[31:0] >> ws;
            OP_SRAW, OP_SRAIW: w = 32'($signed(s1[31:0]) >>> ws);
            OP_LUI:            res = im;
            OP_AUIPC:          res = p + im;
            OP_JAL, OP_JALR:   res = p + INSN_BYTES;
            OP_LOAD, OP_STORE:
            begin
                res = s1 + im;
                wr = 1'b0;
            end
            OP_BEQ:  redir = (s1 == s2);
            OP_BNE:  redir = (s1 != s2);
            OP_BLT:  redir = ($signed(s1) < $signed(s2));
            OP_BGE:  redir = ($signed(s1) >= $signed(s2));
            OP_BLTU: redir = (s1 < s2);
            OP_BGEU: redir = (s1 >= s2);
            default: wr = 1'b0;
        endcase
        if (o inside {OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                      OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW})
            res = {{32{w[31]}}, w};
        if (o inside {OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU})
            wr = 1'b0;
        if (o == OP_JAL || o == OP_JALR)
            redir = 1'b1;
        ld = (o == OP_LOAD);
        if (!redir)
            npc = p + INSN_BYTES;
        else if (o == OP_JALR)
            npc = (s1 + im) & ~xword_t'(1);
        else
            npc = p + im;
    endfunction

    task automatic check_word(input string field, input xword_t expected, input xword_t actual);
        if (expected !== actual)
        begin
            word_errors++;
            $display("Fail %s %s: expected %h, actual %h", test_name, field, expected, actual);
        end
    endtask

    task automatic check_flag(input string field, input logic expected, input logic actual);
        if (expected !== actual)
        begin
            flag_errors++;
            $display("Fail %s %s: expected %b, actual %b", test_name, field, expected, actual);
        end
    endtask

    task automatic check_regno(input string field, input regno_t expected, input regno_t actual);
        if (expected !== actual)
        begin
            regno_errors++;
            $display("Fail %s %s: expected %0d, actual %0d", test_name, field, expected, actual);
        end
    endtask

    task automatic check_op(input string field, input op_e expected, input op_e actual);
        if (expected !== actual)
        begin
            op_errors++;
            $display("Fail %s %s: expected %s, actual %s", test_name, field, expected.name(),
                     actual.name());
        end
    endtask

    task automatic clear_forwarding();
        alu_rd = '0;
        alu_write_rd = 1'b0;
        alu_load = 1'b0;
        alu_result = '0;
        mm_rd = '0;
        mm_write_rd = 1'b0;
        mm_load = 1'b0;
        mm_result = '0;
        mm_mdata = '0;
        wb_rd = '0;
        wb_write_rd = 1'b0;
        wb_data = '0;
    endtask

    // Offer one instruction for a cycle, called 2 units after a rising edge
    task automatic offer(input op_e o, input regno_t d, input regno_t r1, input regno_t r2,
        input xword_t v1, input xword_t v2, input xword_t im, input xword_t p, input logic fl);
        xword_t a;
        xword_t b;
        logic   stall;
        op = o;
        rd = d;
        rs1 = r1;
        rs2 = r2;
        rs1_value = v1;
        rs2_value = v2;
        imm = im;
        pc = p;
        flush = fl;
        in_valid = 1'b1;
        a = resolve_src(reads_rs1(o) ? r1 : regno_t'(0), v1);
        b = resolve_src(r2, v2);
        stall = alu_load && (alu_rd != '0) &&
                ((reads_rs1(o) && r1 == alu_rd) || (reads_rs2(o) && r2 == alu_rd));
        ref_execute(o, a, b, im, p, exp_result, exp_write_rd, exp_load, exp_redirect,
                    exp_next_pc);
        exp_store_data = b;
        exp_rd = d;
        exp_op = o;
        exp_accept = !fl && !stall;
        #1;
        check_flag("ready", !stall, ready);
        @(posedge clk);
        #2;
    endtask

    task automatic idle(input int cycles);
        in_valid = 1'b0;
        flush = 1'b0;
        exp_accept = 1'b0;
        repeat (cycles)
        begin
            @(posedge clk);
            #2;
        end
    endtask

    task automatic offer_random(input op_e o, input xword_t v1, input xword_t im);
        offer(o, regno_t'(rand_bits(5)), regno_t'(rand_bits(5)), regno_t'(rand_bits(5)),
              v1, rand_bits(64), im, rand_bits(62) << 2, 1'b0);
    endtask

    // Snapshot at the edge, compare at the falling edge where outputs are settled
    initial
    begin
        logic   acc;
        logic   wr;
        logic   ld;
        logic   redir;
        xword_t res;
        xword_t sd;
        xword_t npc;
        regno_t d;
        op_e    opc;
        forever
        begin
            @(posedge clk);
            acc = exp_accept && !reset;
            wr = exp_write_rd;
            ld = exp_load;
            redir = exp_redirect;
            res = exp_result;
            sd = exp_store_data;
            npc = exp_next_pc;
            d = exp_rd;
            opc = exp_op;
            @(negedge clk);
            check_flag("out_valid", acc, out_valid);
            check_flag("out_write_rd", acc && wr, out_write_rd);
            check_flag("out_load", acc && ld, out_load);
            check_flag("out_redirect", acc && redir, out_redirect);
            if (acc)
            begin
                check_word("out_result", res, out_result);
                check_word("out_store_data", sd, out_store_data);
                check_word("out_next_pc", npc, out_next_pc);
                check_regno("out_rd", d, out_rd);
                check_op("out_op", opc, out_op);
            end
        end
    end

    initial
    begin
        #(TIMEOUT);
        $display("Timeout: the tests did not finish in %0d time units", TIMEOUT);
        $display("TESTBENCH FAILED");
        $finish;
    end

    initial
    begin
        op_e alu_ops[19] = '{OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU, OP_XOR, OP_SRL, OP_SRA,
                             OP_OR, OP_AND, OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
                             OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI};
        op_e w_ops[9] = '{OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
                          OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW};
        op_e br_ops[6] = '{OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU};
        xword_t v;
        lfsr_state = 32'd6;
        word_errors = 0;
        flag_errors = 0;
        regno_errors = 0;
        op_errors = 0;
        test_name = "reset";
        reset = 1'b1;
        in_valid = 1'b0;
        flush = 1'b0;
        op = OP_NOP;
        rd = '0;
        rs1 = '0;
        rs2 = '0;
        rs1_value = '0;
        rs2_value = '0;
        imm = '0;
        pc = '0;
        exp_accept = 1'b0;
        exp_op = OP_NOP;
        clear_forwarding();
        repeat (8) @(posedge clk);
        #2;
        reset = 1'b0;
        idle(1);

        test_name = "alu_ops";
        for (int i = 0; i < ALU_TESTS; i++)
            offer_random(alu_ops[int'(rand_bits(5)) % 19], rand_bits(64), rand_bits(64));

        test_name = "word_ops";
        for (int i = 0; i < W_TESTS; i++)
        begin
            // Bit 31 set, shift amounts with bit 5 set to catch a 6-bit shift
            v = rand_bits(64) | xword_t'(32'h8000_0000);
            offer_random(w_ops[i % 9], v, (rand_bits(58) << 6) | xword_t'(32) | rand_bits(5));
        end

        test_name = "branches";
        for (int i = 0; i < 12; i++)
        begin
            v = rand_bits(64);
            offer(br_ops[i % 6], 5'd0, 5'd1, 5'd2, v, (i < 6) ? v : rand_bits(64),
                  rand_bits(12) << 1, rand_bits(62) << 2, 1'b0);
        end
        offer(OP_JAL, 5'd1, 5'd0, 5'd0, '0, '0, 64'h800, 64'h1000, 1'b0);
        offer(OP_JALR, 5'd1, 5'd5, 5'd0, 64'h2001, '0, 64'h10, 64'h1000, 1'b0);

        test_name = "forwarding";
        alu_rd = 5'd9;
        alu_write_rd = 1'b1;
        alu_result = 64'h1111;
        mm_rd = 5'd9;
        mm_write_rd = 1'b1;
        mm_result = 64'h2222;
        mm_mdata = 64'h3333;
        wb_rd = 5'd9;
        wb_write_rd = 1'b1;
        wb_data = 64'h4444;
        offer(OP_ADD, 5'd4, 5'd9, 5'd9, 64'h5, 64'h6, '0, '0, 1'b0);
        offer(OP_STORE, 5'd0, 5'd3, 5'd9, 64'h100, 64'h6, 64'h8, '0, 1'b0);
        alu_write_rd = 1'b0;
        offer(OP_ADD, 5'd4, 5'd9, 5'd9, 64'h5, 64'h6, '0, '0, 1'b0);
        mm_load = 1'b1;
        offer(OP_ADD, 5'd4, 5'd9, 5'd9, 64'h5, 64'h6, '0, '0, 1'b0);
        mm_load = 1'b0;
        mm_write_rd = 1'b0;
        offer(OP_ADD, 5'd4, 5'd9, 5'd9, 64'h5, 64'h6, '0, '0, 1'b0);
        alu_rd = 5'd0;
        alu_write_rd = 1'b1;
        mm_rd = 5'd0;
        mm_write_rd = 1'b1;
        wb_rd = 5'd0;
        offer(OP_ADD, 5'd4, 5'd0, 5'd0, 64'h5, 64'h6, '0, '0, 1'b0);
        clear_forwarding();

        test_name = "load_use";
        alu_rd = 5'd7;
        alu_load = 1'b1;
        offer(OP_ADD, 5'd8, 5'd7, 5'd2, 64'h5, 64'h6, '0, '0, 1'b0);
        offer(OP_ADD, 5'd8, 5'd7, 5'd2, 64'h5, 64'h6, '0, '0, 1'b0);
        alu_rd = 5'd0;
        alu_load = 1'b0;
        mm_rd = 5'd7;
        mm_load = 1'b1;
        mm_mdata = 64'hdead_beef_0000_0042;
        offer(OP_ADD, 5'd8, 5'd7, 5'd2, 64'h5, 64'h6, '0, '0, 1'b0);
        clear_forwarding();

        test_name = "flush";
        offer(OP_ADD, 5'd8, 5'd1, 5'd2, 64'h5, 64'h6, '0, '0, 1'b1);
        idle(3);

        $display("Errors: %0d word, %0d flag, %0d regno, %0d op", word_errors, flag_errors,
                 regno_errors, op_errors);
        if (word_errors + flag_errors + regno_errors + op_errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
design/ex_pkg.sv
design/operand_forward.sv
design/int_alu.sv
design/branch_resolve.sv
design/execute_stage.sv
verif/execute_stage_assertions.sv
verif/execute_stage_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module execute_stage_tb -f compile.f

output=$(./obj_dir/Vexecute_stage_tb)
echo "$output"

if echo "$output" | grep -q "TESTBENCH PASSED"; then
    exit 0
fi
exit 1
